// ==== GshareTop.f ====
design/GsharePkg.sv
design/PhtRam.sv
design/PhtWriteQueue.sv
design/GshareIndexStage.sv
design/GsharePredictStage.sv
design/GshareTrainStage.sv
design/GshareTop.sv
sim/TbClock.sv
sim/Gshare_properties.sv
sim/GshareTb.sv

// ==== Makefile ====
SOURCES := $(shell grep -v '^+' GshareTop.f)

all: run

obj_dir/VGshareTb: GshareTop.f $(SOURCES)
	verilator --binary --assert --top-module GshareTb -f GshareTop.f -Mdir obj_dir

run: obj_dir/VGshareTb
	./obj_dir/VGshareTb | tee sim.log
	grep -q "^Verification passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

// ==== design/GshareIndexStage.sv ====
/*
 * Gshare index stage.
 * Holds the global history register, selects its next value and forms
 * the per-slot PHT read indices from the fetch PC and that next history.
 */
`timescale 1ns/1ps

module GshareIndexStage (
    input  logic                clk,
    input  logic                rstN,
    input  logic                fetchValid,
    input  GsharePkg::AddrT     fetchPc,
    input  logic                specUpdate,
    input  GsharePkg::HistoryT  specHistory,
    input  logic                recoverValid,
    input  GsharePkg::HistoryT  recoverHistory,
    output GsharePkg::PhtIndexT readIndex [GsharePkg::FETCH_WIDTH],
    output GsharePkg::HistoryT  curHistory,
    output logic                predValid
);
    import GsharePkg::*;

    HistoryT nextHistory;

    // Recovery beats speculation, otherwise hold.
    always_comb begin
        if (recoverValid) begin
            nextHistory = recoverHistory;
        end else if (specUpdate) begin
            nextHistory = specHistory;
        end else begin
            nextHistory = curHistory;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            curHistory <= '0;
            predValid <= 1'b0;
        end else begin
            curHistory <= nextHistory;
            predValid <= fetchValid;
        end
    end

    // Index uses the history as it stands after this cycle's updates.
    always_comb begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            readIndex[i] = phtIndexOf(fetchPc + AddrT'(i * INSN_BYTES), nextHistory);
        end
    end

endmodule

// ==== design/GsharePkg.sv ====
/*
 * Gshare predictor package.
 * Address and table geometry, typed vectors, branch-result and PHT write
 * records, the train-stage states and the shared PHT index function.
 */
package GsharePkg;

    // Address and fetch geometry.
    localparam int ADDR_WIDTH = 32;
    localparam int INSN_OFFSET_WIDTH = 2;
    localparam int INSN_BYTES = 4;
    localparam int FETCH_WIDTH = 2;
    localparam int UPDATE_WIDTH = 2;

    // Pattern history table and global history.
    localparam int PHT_INDEX_WIDTH = 10;
    localparam int PHT_ENTRY_NUM = 1024;
    localparam int HISTORY_WIDTH = 8;
    localparam int COUNTER_WIDTH = 2;
    localparam int COUNTER_MAX = 3;
    // Weakly taken.
    localparam int COUNTER_INIT = 2;

    // Deferred write queue.
    localparam int WRITE_QUEUE_DEPTH = 4;
    localparam int QUEUE_PTR_WIDTH = 2;

    typedef logic [ADDR_WIDTH-1:0] AddrT;
    typedef logic [PHT_INDEX_WIDTH-1:0] PhtIndexT;
    typedef logic [HISTORY_WIDTH-1:0] HistoryT;
    typedef logic [COUNTER_WIDTH-1:0] CounterT;
    typedef logic [QUEUE_PTR_WIDTH-1:0] QueuePtrT;

    typedef struct packed {
        logic btbHit;
        logic isCondBr;
    } SlotBranchInfoT;

    // One executed branch, with the history and counter it was predicted with.
    typedef struct packed {
        logic valid;
        logic mispred;
        logic isCondBr;
        logic execTaken;
        AddrT brAddr;
        HistoryT history;
        CounterT prevCounter;
    } BranchResultT;

    typedef struct packed {
        PhtIndexT index;
        CounterT value;
    } PhtWriteT;

    typedef enum logic {INIT_SWEEP, RUN} TrainStateT;

    // Word address bits, upper part folded with the global history.
    function automatic PhtIndexT phtIndexOf(input AddrT addr, input HistoryT history);
        PhtIndexT index;
        index = addr[PHT_INDEX_WIDTH+INSN_OFFSET_WIDTH-1:INSN_OFFSET_WIDTH];
        index[PHT_INDEX_WIDTH-1 -: HISTORY_WIDTH] =
            index[PHT_INDEX_WIDTH-1 -: HISTORY_WIDTH] ^ history;
        return index;
    endfunction

endpackage

// ==== design/GsharePredictStage.sv ====
/*
 * Gshare predict stage.
 * Turns the read counters and per-slot BTB information into directions
 * and builds the speculative history, stopping after a taken slot.
 */
`timescale 1ns/1ps

module GsharePredictStage (
    input  logic                      predValid,
    input  GsharePkg::CounterT        readCounter [GsharePkg::FETCH_WIDTH],
    input  GsharePkg::SlotBranchInfoT slotInfo [GsharePkg::FETCH_WIDTH],
    input  GsharePkg::HistoryT        curHistory,
    output logic                      predTaken [GsharePkg::FETCH_WIDTH],
    output GsharePkg::CounterT        predCounter [GsharePkg::FETCH_WIDTH],
    output GsharePkg::HistoryT        predHistory,
    output logic                      specUpdate,
    output GsharePkg::HistoryT        specHistory
);
    import GsharePkg::*;

    always_comb begin
        logic stopped;
        logic shifted;
        stopped = 1'b0;
        shifted = 1'b0;
        specHistory = curHistory;

        for (int i = 0; i < FETCH_WIDTH; i++) begin
            // Counter MSB gives the direction, but only on a BTB hit.
            predTaken[i] = readCounter[i][COUNTER_WIDTH-1] && slotInfo[i].btbHit;
            predCounter[i] = readCounter[i];

            if (!stopped && slotInfo[i].btbHit && slotInfo[i].isCondBr) begin
                specHistory = {specHistory[HISTORY_WIDTH-2:0], predTaken[i]};
                shifted = 1'b1;
            end
            // Slots behind a taken branch are not executed.
            if (predTaken[i]) begin
                stopped = 1'b1;
            end
        end

        specUpdate = predValid && shifted;
    end

    // Travels with the fetch group for recovery.
    assign predHistory = curHistory;

endmodule

// ==== design/GshareTop.sv ====
/*
 * Gshare direction predictor, top level.
 * Two-wide prediction with speculative global history, two training
 * results per cycle through a deferred write queue, and init sweep.
 */
`timescale 1ns/1ps

module GshareTop (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic                      fetchValid,
    input  GsharePkg::AddrT           fetchPc,
    input  GsharePkg::SlotBranchInfoT slotInfo [GsharePkg::FETCH_WIDTH],
    input  GsharePkg::BranchResultT   brResult [GsharePkg::UPDATE_WIDTH],
    output logic                      predValid,
    output logic                      predTaken [GsharePkg::FETCH_WIDTH],
    output GsharePkg::CounterT        predCounter [GsharePkg::FETCH_WIDTH],
    output GsharePkg::HistoryT        predHistory,
    output logic                      ready,
    output logic                      queueFull
);
    import GsharePkg::*;

    PhtIndexT readIndex [FETCH_WIDTH];
    CounterT readCounter [FETCH_WIDTH];
    HistoryT curHistory;
    HistoryT specHistory;
    logic specUpdate;
    logic recoverValid;
    HistoryT recoverHistory;
    logic writeEnable [UPDATE_WIDTH];
    PhtWriteT write [UPDATE_WIDTH];
    logic push;
    logic pop;
    logic queueEmpty;
    PhtWriteT pushEntry;
    PhtWriteT headEntry;

    GshareIndexStage u_index (
        .clk, .rstN, .fetchValid, .fetchPc, .specUpdate, .specHistory,
        .recoverValid, .recoverHistory, .readIndex, .curHistory, .predValid
    );

    PhtRam u_pht (.clk, .readIndex, .writeEnable, .write, .readCounter);

    GsharePredictStage u_predict (
        .predValid, .readCounter, .slotInfo, .curHistory, .predTaken,
        .predCounter, .predHistory, .specUpdate, .specHistory
    );

    GshareTrainStage u_train (
        .clk, .rstN, .brResult, .headEntry, .queueEmpty, .writeEnable, .write,
        .push, .pushEntry, .pop, .recoverValid, .recoverHistory, .ready
    );

    PhtWriteQueue u_queue (
        .clk, .rstN, .push, .pushEntry, .pop, .headEntry,
        .full(queueFull), .empty(queueEmpty)
    );

endmodule

// ==== design/GshareTrainStage.sv ====
/*
 * Gshare train stage.
 * Runs the PHT init sweep, then updates saturating counters from branch
 * results, arbitrates direct writes against queue drain and recovers
 * the global history on a misprediction.
 */
`timescale 1ns/1ps

module GshareTrainStage (
    input  logic                    clk,
    input  logic                    rstN,
    input  GsharePkg::BranchResultT brResult [GsharePkg::UPDATE_WIDTH],
    input  GsharePkg::PhtWriteT     headEntry,
    input  logic                    queueEmpty,
    output logic                    writeEnable [GsharePkg::UPDATE_WIDTH],
    output GsharePkg::PhtWriteT     write [GsharePkg::UPDATE_WIDTH],
    output logic                    push,
    output GsharePkg::PhtWriteT     pushEntry,
    output logic                    pop,
    output logic                    recoverValid,
    output GsharePkg::HistoryT      recoverHistory,
    output logic                    ready
);
    import GsharePkg::*;

    TrainStateT state;
    PhtIndexT sweepIndex;
    PhtWriteT resEntry [UPDATE_WIDTH];

    function automatic CounterT satUpdate(input CounterT prev, input logic taken);
        CounterT next;
        if (taken) begin
            next = (prev == CounterT'(COUNTER_MAX)) ? prev : prev + 1'b1;
        end else begin
            next = (prev == '0) ? prev : prev - 1'b1;
        end
        return next;
    endfunction

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= INIT_SWEEP;
            sweepIndex <= '0;
        end else if (state == INIT_SWEEP) begin
            sweepIndex <= sweepIndex + 1'b1;
            if (sweepIndex == PhtIndexT'(PHT_ENTRY_NUM - 1)) begin
                state <= RUN;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < UPDATE_WIDTH; i++) begin
            resEntry[i].index = phtIndexOf(brResult[i].brAddr, brResult[i].history);
            resEntry[i].value = satUpdate(brResult[i].prevCounter, brResult[i].execTaken);
        end
    end

    always_comb begin
        logic directDone;
        directDone = 1'b0;
        push = 1'b0;
        pop = 1'b0;
        pushEntry = resEntry[UPDATE_WIDTH-1];
        recoverValid = 1'b0;
        recoverHistory = '0;
        for (int i = 0; i < UPDATE_WIDTH; i++) begin
            writeEnable[i] = 1'b0;
            write[i] = resEntry[i];
        end

        if (state == INIT_SWEEP) begin
            writeEnable[0] = 1'b1;
            write[0] = '{index: sweepIndex, value: CounterT'(COUNTER_INIT)};
        end else begin
            for (int i = 0; i < UPDATE_WIDTH; i++) begin
                // First valid result writes directly, later ones are deferred.
                if (brResult[i].valid) begin
                    if (directDone) begin
                        push = 1'b1;
                        pushEntry = resEntry[i];
                    end else begin
                        writeEnable[i] = 1'b1;
                        directDone = 1'b1;
                    end
                end
                // Last mispredicted result decides the history.
                if (brResult[i].valid && brResult[i].mispred) begin
                    recoverValid = 1'b1;
                    recoverHistory = brResult[i].isCondBr ?
                        {brResult[i].history[HISTORY_WIDTH-2:0], brResult[i].execTaken} :
                        brResult[i].history;
                end
            end
            // Drain one queued write on an idle port 0.
            if (!directDone && !queueEmpty) begin
                writeEnable[0] = 1'b1;
                write[0] = headEntry;
                pop = 1'b1;
            end
        end
    end

    assign ready = (state == RUN);

endmodule

// ==== design/PhtRam.sv ====
/*
 * PHT counter storage.
 * One bank per read port, each bank a full copy kept coherent by both
 * write ports. Reads are registered; port 0 wins a same-index write.
 */
`timescale 1ns/1ps

module PhtRam (
    input  logic                 clk,
    input  GsharePkg::PhtIndexT  readIndex [GsharePkg::FETCH_WIDTH],
    input  logic                 writeEnable [GsharePkg::UPDATE_WIDTH],
    input  GsharePkg::PhtWriteT  write [GsharePkg::UPDATE_WIDTH],
    output GsharePkg::CounterT   readCounter [GsharePkg::FETCH_WIDTH]
);
    import GsharePkg::*;

    for (genvar b = 0; b < FETCH_WIDTH; b++) begin : gBank
        CounterT mem [PHT_ENTRY_NUM];

        // Highest port first, so port 0 lands last on a collision.
        always_ff @(posedge clk) begin
            for (int w = UPDATE_WIDTH - 1; w >= 0; w--) begin
                if (writeEnable[w]) begin
                    mem[write[w].index] <= write[w].value;
                end
            end
        end

        // Read sees the value before this edge's writes.
        always_ff @(posedge clk) begin
            readCounter[b] <= mem[readIndex[b]];
        end
    end

endmodule

// ==== design/PhtWriteQueue.sv ====
/*
 * Deferred PHT write queue.
 * Small circular buffer with head and tail pointers and an occupancy
 * count. Push while full is only taken together with a pop.
 */
`timescale 1ns/1ps

module PhtWriteQueue (
    input  logic                clk,
    input  logic                rstN,
    input  logic                push,
    input  GsharePkg::PhtWriteT pushEntry,
    input  logic                pop,
    output GsharePkg::PhtWriteT headEntry,
    output logic                full,
    output logic                empty
);
    import GsharePkg::*;

    PhtWriteT entries [WRITE_QUEUE_DEPTH];
    QueuePtrT headPtr;
    QueuePtrT tailPtr;
    logic [QUEUE_PTR_WIDTH:0] count;
    logic doPush;
    logic doPop;

    assign doPop = pop && !empty;
    assign doPush = push && (!full || doPop);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            headPtr <= '0;
            tailPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                tailPtr <= tailPtr + 1'b1;
            end
            if (doPop) begin
                headPtr <= headPtr + 1'b1;
            end
            case ({doPush, doPop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (doPush) begin
            entries[tailPtr] <= pushEntry;
        end
    end

    assign headEntry = entries[headPtr];
    assign full = (count == (QUEUE_PTR_WIDTH + 1)'(WRITE_QUEUE_DEPTH));
    assign empty = (count == '0);

endmodule

// ==== sim/GshareTb.sv ====
/*
 * Gshare predictor testbench.
 * Directed tests checked against a reference PHT and global history model.
 */
`timescale 1ns/1ps

module GshareTb;
    import GsharePkg::*;

    // Sweep plus generous room for the directed tests.
    localparam int TIMEOUT_CYCLES = PHT_ENTRY_NUM + 2000;

    logic clk;
    logic rstN;
    logic fetchValid;
    AddrT fetchPc;
    SlotBranchInfoT slotInfo [FETCH_WIDTH];
    BranchResultT brResult [UPDATE_WIDTH];
    logic predValid;
    logic predTaken [FETCH_WIDTH];
    CounterT predCounter [FETCH_WIDTH];
    HistoryT predHistory;
    logic ready;
    logic queueFull;

    CounterT modelPht [PHT_ENTRY_NUM];
    HistoryT modelHistory;
    int checkCount = 0;
    int errorCount = 0;
    int cycleCount = 0;

    TbClock u_clock (.clk);

    GshareTop u_dut (
        .clk, .rstN, .fetchValid, .fetchPc, .slotInfo, .brResult, .predValid,
        .predTaken, .predCounter, .predHistory, .ready, .queueFull
    );

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the tests did not finish", cycleCount);
            $display("Verification failed");
            $finish;
        end
    end

    task automatic compareValue(input string name, input logic [31:0] got,
            input logic [31:0] exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic checkTaken(input string name, input logic got, input logic exp);
        compareValue(name, 32'(got), 32'(exp));
    endtask

    task automatic checkLevel(input string name, input logic got, input logic exp);
        compareValue(name, 32'(got), 32'(exp));
    endtask

    task automatic checkCounter(input string name, input CounterT got, input CounterT exp);
        compareValue(name, 32'(got), 32'(exp));
    endtask

    task automatic checkHistory(input string name, input HistoryT got, input HistoryT exp);
        compareValue(name, 32'(got), 32'(exp));
    endtask

    // Word address bits [11:2] with the upper eight XORed with the history.
    function automatic PhtIndexT refIndex(input AddrT pc, input HistoryT hist);
        return {pc[11:4] ^ hist, pc[3:2]};
    endfunction

    function automatic CounterT refCount(input CounterT prev, input logic taken);
        if (taken) begin
            return (prev == 2'd3) ? prev : prev + 2'd1;
        end
        return (prev == 2'd0) ? prev : prev - 2'd1;
    endfunction

    function automatic AddrT randomPc();
        AddrT pc;
        pc = $urandom();
        pc[1:0] = 2'b00;
        return pc;
    endfunction

    // The counter travels back as the model last saw it.
    function automatic BranchResultT makeResult(input AddrT pc, input logic taken,
            input logic mispred, input logic isCond, input HistoryT hist);
        BranchResultT r;
        r = '{valid: 1'b1, mispred: mispred, isCondBr: isCond, execTaken: taken,
              brAddr: pc, history: hist, prevCounter: modelPht[refIndex(pc, hist)]};
        return r;
    endfunction

    task automatic applyToModel(input BranchResultT r);
        if (r.valid) begin
            modelPht[refIndex(r.brAddr, r.history)] = refCount(r.prevCounter, r.execTaken);
            if (r.mispred) begin
                modelHistory = r.isCondBr ? {r.history[HISTORY_WIDTH-2:0], r.execTaken} :
                    r.history;
            end
        end
    endtask

    task automatic sendResults(input BranchResultT r0, input BranchResultT r1);
        @(posedge clk);
        brResult[0] <= r0;
        brResult[1] <= r1;
        @(posedge clk);
        brResult[0] <= '0;
        brResult[1] <= '0;
        applyToModel(r0);
        applyToModel(r1);
    endtask

    // Fetches one group, checks it slot by slot and advances the model history.
    task automatic fetchGroup(input AddrT pc, input SlotBranchInfoT s0,
            input SlotBranchInfoT s1);
        SlotBranchInfoT info [FETCH_WIDTH];
        CounterT expCnt;
        logic expTaken;
        logic stop;
        HistoryT expHist;
        info[0] = s0;
        info[1] = s1;
        @(posedge clk);
        fetchValid <= 1'b1;
        fetchPc <= pc;
        @(posedge clk);
        fetchValid <= 1'b0;
        slotInfo[0] <= s0;
        slotInfo[1] <= s1;
        @(negedge clk);
        checkLevel("predValid", predValid, 1'b1);
        checkHistory("predHistory", predHistory, modelHistory);
        expHist = modelHistory;
        stop = 1'b0;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            expCnt = modelPht[refIndex(pc + AddrT'(i * INSN_BYTES), modelHistory)];
            expTaken = expCnt[COUNTER_WIDTH-1] && info[i].btbHit;
            checkCounter($sformatf("predCounter[%0d]", i), predCounter[i], expCnt);
            checkTaken($sformatf("predTaken[%0d]", i), predTaken[i], expTaken);
            if (!stop && info[i].btbHit && info[i].isCondBr) begin
                expHist = {expHist[HISTORY_WIDTH-2:0], expTaken};
            end
            stop = stop || expTaken;
        end
        modelHistory = expHist;
        @(posedge clk);
        slotInfo[0] <= '0;
        slotInfo[1] <= '0;
    endtask

    task automatic testInitSweep();
        int edges;
        SlotBranchInfoT hit;
        edges = 0;
        hit = '{btbHit: 1'b1, isCondBr: 1'b0};
        do begin
            @(posedge clk);
            edges++;
            @(negedge clk);
        end while (!ready && edges < PHT_ENTRY_NUM + 16);
        if (!ready) begin
            errorCount++;
            $display("ready did not rise within %0d cycles of reset release", edges);
        end else begin
            compareValue("ready rise cycle", 32'(edges), 32'(PHT_ENTRY_NUM));
        end
        checkLevel("queueFull", queueFull, 1'b0);
        repeat (6) fetchGroup(randomPc(), hit, hit);
    endtask

    // Counter walks 2, 1, 0, 0 and then back up to 3 and stays.
    task automatic testSaturation();
        AddrT pc;
        logic dirs [7];
        BranchResultT result;
        pc = randomPc();
        dirs = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1};
        foreach (dirs[k]) begin
            fetchGroup(pc, '0, '0);
            result = makeResult(pc, dirs[k], 1'b0, 1'b1, modelHistory);
            // Odd steps train through the second result slot.
            if (k % 2 == 1) begin
                sendResults('0, result);
            end else begin
                sendResults(result, '0);
            end
        end
        fetchGroup(pc, '0, '0);
    endtask

    task automatic testSpecHistory();
        SlotBranchInfoT cond;
        SlotBranchInfoT plain;
        AddrT pc;
        cond = '{btbHit: 1'b1, isCondBr: 1'b1};
        plain = '{btbHit: 1'b1, isCondBr: 1'b0};
        fetchGroup(randomPc(), cond, cond);
        fetchGroup(randomPc(), plain, cond);
        fetchGroup(randomPc(), '0, cond);
        // Weakened slot 0 predicts not taken, so slot 1 shifts in as well.
        pc = randomPc();
        repeat (2) sendResults(makeResult(pc, 1'b0, 1'b0, 1'b1, modelHistory), '0);
        fetchGroup(pc, cond, cond);
        repeat (4) begin
            fetchGroup(randomPc(), SlotBranchInfoT'(2'($urandom())),
                SlotBranchInfoT'(2'($urandom())));
        end
        fetchGroup(randomPc(), '0, '0);
    endtask

    task automatic testRecovery();
        logic taken;
        taken = 1'($urandom());
        sendResults(makeResult(randomPc(), taken, 1'b1, 1'b1, 8'($urandom())), '0);
        fetchGroup(randomPc(), '0, '0);
        sendResults(makeResult(randomPc(), taken, 1'b1, 1'b0, 8'($urandom())), '0);
        fetchGroup(randomPc(), '0, '0);
        // With two mispredictions together the later one decides.
        sendResults(makeResult(randomPc(), 1'b1, 1'b1, 1'b1, 8'($urandom())),
            makeResult(randomPc(), 1'b0, 1'b1, 1'b0, 8'($urandom())));
        fetchGroup(randomPc(), '0, '0);
    endtask

    task automatic testQueue();
        AddrT base;
        BranchResultT r0;
        BranchResultT r1;
        int sent;
        int occupancy;
        logic pushing;
        base = randomPc();
        base[2] = 1'b0;
        sent = 0;
        occupancy = 0;
        while (sent < 6 || occupancy > 0) begin
            @(posedge clk);
            pushing = (sent < 6) && (occupancy < WRITE_QUEUE_DEPTH);
            r0 = '0;
            r1 = '0;
            if (pushing) begin
                r0 = makeResult(base + AddrT'(8 * sent), 1'($urandom()), 1'b0, 1'b1,
                    modelHistory);
                r1 = makeResult(base + AddrT'(8 * sent + 4), 1'($urandom()), 1'b0, 1'b1,
                    modelHistory);
                applyToModel(r0);
                applyToModel(r1);
                sent++;
            end
            brResult[0] <= r0;
            brResult[1] <= r1;
            @(negedge clk);
            checkLevel("queueFull", queueFull, occupancy == WRITE_QUEUE_DEPTH);
            // A pair pushes one entry, an idle cycle drains one.
            occupancy = pushing ? occupancy + 1 : occupancy - 1;
        end
        @(posedge clk);
        brResult[0] <= '0;
        brResult[1] <= '0;
        for (int k = 0; k < 6; k++) begin
            fetchGroup(base + AddrT'(8 * k), '0, '0);
        end
    endtask

    initial begin
        int unsigned seedValue;
        seedValue = $urandom(32'hf35b85cd);
        rstN = 1'b0;
        fetchValid = 1'b0;
        fetchPc = '0;
        slotInfo[0] = '0;
        slotInfo[1] = '0;
        brResult[0] = '0;
        brResult[1] = '0;
        modelHistory = '0;
        foreach (modelPht[i]) begin
            modelPht[i] = CounterT'(COUNTER_INIT);
        end
        repeat (4) @(posedge clk);
        rstN <= 1'b1;
        testInitSweep();
        testSaturation();
        testSpecHistory();
        testRecovery();
        testQueue();
        repeat (2) @(posedge clk);
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== sim/Gshare_properties.sv ====
/*
 * Gshare predictor assertions.
 * Queue back-pressure, one-cycle prediction latency, quiet training
 * ports during the init sweep and a ready level that stays high.
 */
`timescale 1ns/1ps

module GshareProperties (
    input logic                clk,
    input logic                rstN,
    input logic                fetchValid,
    input logic                predValid,
    input logic                ready,
    input logic                queueFull,
    input logic                push,
    input logic                writeEnable0,
    input logic                writeEnable1,
    input GsharePkg::PhtWriteT write0
);
    import GsharePkg::*;

    // A second result must not arrive while the queue is full.
    assert property (@(posedge clk) disable iff (!rstN) !(push && queueFull))
        else $error("write queue push while full");

    assert property (@(posedge clk) disable iff (!rstN) fetchValid |=> predValid)
        else $error("predValid missing one cycle after fetchValid");

    assert property (@(posedge clk) disable iff (!rstN) predValid |-> $past(fetchValid))
        else $error("predValid without a fetch in the previous cycle");

    // Before ready only the sweep writes, and only the init value.
    assert property (@(posedge clk) disable iff (!rstN)
        !ready |-> !writeEnable1 && (!writeEnable0 || write0.value == CounterT'(COUNTER_INIT)))
        else $error("training write before the init sweep ended");

    assert property (@(posedge clk) disable iff (!rstN) ready |=> ready)
        else $error("ready fell after rising");

endmodule

bind GshareTop GshareProperties u_props (
    .clk, .rstN, .fetchValid, .predValid, .ready, .queueFull, .push,
    .writeEnable0(writeEnable[0]), .writeEnable1(writeEnable[1]), .write0(write[0])
);

// ==== sim/TbClock.sv ====
/*
 * Testbench clock generator, 10 ns period.
 */
`timescale 1ns/1ps

module TbClock (
    output logic clk
);
    localparam int HALF_PERIOD = 5;

    initial begin
        clk = 1'b0;
    end

    always begin
        #HALF_PERIOD clk = ~clk;
    end

endmodule
